// File: include/rv_exec_defs.svh
// ------------------------------
// data width, register file size and opcode macros
// ------------------------------

`ifndef RV_EXEC_DEFS_SVH
`define RV_EXEC_DEFS_SVH

// datapath width
`define RV_XLEN 32

// RV32E register file
`define RV_NR_REGS 16
`define RV_REG_AW 4

// the two accepted major opcodes
`define RV_OPC_OP 7'b0110011
`define RV_OPC_OP_IMM 7'b0010011

`endif

// File: rv_exec_core.f
+incdir+include
src/rv_exec_pkg.sv
src/instr_decoder.sv
src/latch_regfile.sv
src/operand_fetch.sv
src/alu_stage.sv
src/rv_exec_core.sv
tests/rv_exec_core_assert.sv
tests/rv_exec_core_tb.sv

// File: src/alu_stage.sv
// ------------------------------
// execute stage and writeback register
// ------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "rv_exec_defs.svh"

module alu_stage (
  input  logic                 clk,
  input  logic                 arst_n_i,
  input  rv_exec_pkg::exe_op_t exe_i,
  output rv_exec_pkg::wb_t     ex_fwd_o,
  output rv_exec_pkg::wb_t     wb_o
);

  import rv_exec_pkg::*;

  logic [`RV_XLEN-1:0] result;
  logic [4:0]          shamt;
  logic                lt_signed;
  logic                lt_unsigned;

  logic                  valid_q;
  logic                  illegal_q;
  logic [`RV_REG_AW-1:0] rd_q;
  logic [`RV_XLEN-1:0]   data_q;

  // shifts only look at the low 5 bits
  assign shamt       = exe_i.b[4:0];
  assign lt_signed   = $signed(exe_i.a) < $signed(exe_i.b);
  assign lt_unsigned = exe_i.a < exe_i.b;

  always_comb begin
    case (exe_i.alu_op)
      ALU_ADD:  result = exe_i.a + exe_i.b;
      ALU_SUB:  result = exe_i.a - exe_i.b;
      ALU_AND:  result = exe_i.a & exe_i.b;
      ALU_OR:   result = exe_i.a | exe_i.b;
      ALU_XOR:  result = exe_i.a ^ exe_i.b;
      ALU_SLL:  result = exe_i.a << shamt;
      ALU_SRL:  result = exe_i.a >> shamt;
      ALU_SRA:  result = $signed(exe_i.a) >>> shamt;
      ALU_SLT:  result = {{(`RV_XLEN-1){1'b0}}, lt_signed};
      ALU_SLTU: result = {{(`RV_XLEN-1){1'b0}}, lt_unsigned};
      default:  result = '0;
    endcase
  end

  // distance 1 bypass
  assign ex_fwd_o = '{valid: exe_i.valid, illegal: exe_i.illegal, rd: exe_i.rd,
                      data: result};

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q   <= 1'b0;
      illegal_q <= 1'b0;
    end else begin
      valid_q   <= ex_fwd_o.valid;
      illegal_q <= ex_fwd_o.illegal;
    end
  end

  always_ff @(posedge clk) begin
    rd_q   <= ex_fwd_o.rd;
    data_q <= ex_fwd_o.data;
  end

  assign wb_o = '{valid: valid_q, illegal: illegal_q, rd: rd_q, data: data_q};

endmodule

`default_nettype wire

// File: src/instr_decoder.sv
// ------------------------------
// decode stage for RV32E OP and OP-IMM
// ------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "rv_exec_defs.svh"

module instr_decoder (
  input  logic                 clk,
  input  logic                 arst_n_i,
  input  logic                 instr_valid_i,
  input  rv_exec_pkg::instr_t  instr_i,
  output rv_exec_pkg::dec_op_t dec_o
);

  import rv_exec_pkg::*;

  logic                illegal;
  alu_op_e             alu_op;
  logic                use_imm;
  logic [4:0]          rd_f;
  logic [4:0]          rs1_f;
  logic [4:0]          rs2_f;
  logic [`RV_XLEN-1:0] imm;

  // stage register
  logic                  valid_q;
  logic                  illegal_q;
  alu_op_e               alu_op_q;
  logic [`RV_REG_AW-1:0] rd_q;
  logic [`RV_REG_AW-1:0] rs1_q;
  logic [`RV_REG_AW-1:0] rs2_q;
  logic                  use_imm_q;
  logic [`RV_XLEN-1:0]   imm_q;

  always_comb begin
    illegal = 1'b0;
    alu_op  = ALU_ADD;
    use_imm = 1'b0;
    rd_f    = instr_i.r.rd;
    rs1_f   = instr_i.r.rs1;
    rs2_f   = instr_i.r.rs2;
    // sign extended imm12
    imm     = {{(`RV_XLEN-12){instr_i.i.imm12[11]}}, instr_i.i.imm12};

    case (instr_i.r.opcode)
      `RV_OPC_OP: begin
        case ({instr_i.r.funct7, instr_i.r.funct3})
          {7'h00, 3'b000}: alu_op = ALU_ADD;
          {7'h20, 3'b000}: alu_op = ALU_SUB;
          {7'h00, 3'b001}: alu_op = ALU_SLL;
          {7'h00, 3'b010}: alu_op = ALU_SLT;
          {7'h00, 3'b011}: alu_op = ALU_SLTU;
          {7'h00, 3'b100}: alu_op = ALU_XOR;
          {7'h00, 3'b101}: alu_op = ALU_SRL;
          {7'h20, 3'b101}: alu_op = ALU_SRA;
          {7'h00, 3'b110}: alu_op = ALU_OR;
          {7'h00, 3'b111}: alu_op = ALU_AND;
          default:         illegal = 1'b1;
        endcase
      end
      `RV_OPC_OP_IMM: begin
        use_imm = 1'b1;
        // no second source register
        rs2_f   = '0;
        case (instr_i.i.funct3)
          3'b000: alu_op = ALU_ADD;
          3'b010: alu_op = ALU_SLT;
          3'b011: alu_op = ALU_SLTU;
          3'b100: alu_op = ALU_XOR;
          3'b110: alu_op = ALU_OR;
          3'b111: alu_op = ALU_AND;
          3'b001: begin
            if (instr_i.i.imm12[11:5] == 7'h00) alu_op = ALU_SLL;
            else illegal = 1'b1;
          end
          default: begin
            // funct7 slot of the immediate picks logical or arithmetic
            if (instr_i.i.imm12[11:5] == 7'h00) alu_op = ALU_SRL;
            else if (instr_i.i.imm12[11:5] == 7'h20) alu_op = ALU_SRA;
            else illegal = 1'b1;
          end
        endcase
      end
      default: illegal = 1'b1;
    endcase

    // x16 and above do not exist in RV32E
    if (rd_f[4] || rs1_f[4] || rs2_f[4]) illegal = 1'b1;
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q   <= 1'b0;
      illegal_q <= 1'b0;
    end else begin
      valid_q   <= instr_valid_i & ~illegal;
      illegal_q <= instr_valid_i & illegal;
    end
  end

  always_ff @(posedge clk) begin
    alu_op_q  <= alu_op;
    rd_q      <= rd_f[`RV_REG_AW-1:0];
    rs1_q     <= rs1_f[`RV_REG_AW-1:0];
    rs2_q     <= rs2_f[`RV_REG_AW-1:0];
    use_imm_q <= use_imm;
    imm_q     <= imm;
  end

  assign dec_o = '{valid: valid_q, illegal: illegal_q, alu_op: alu_op_q, rd: rd_q,
                   rs1: rs1_q, rs2: rs2_q, use_imm: use_imm_q, imm: imm_q};

endmodule

`default_nettype wire

// File: src/latch_regfile.sv
// ------------------------------
// latch register file, 2 read and 1 write port
// ------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "rv_exec_defs.svh"

module latch_regfile (
  input  logic                             clk,
  // read ports
  input  logic [1:0][`RV_REG_AW-1:0]       raddr_i,
  output logic [1:0][`RV_XLEN-1:0]         rdata_o,
  // write port
  input  logic                             we_i,
  input  logic [`RV_REG_AW-1:0]            waddr_i,
  input  logic [`RV_XLEN-1:0]              wdata_i
);

  logic                       we_en_q;
  logic                       clk_wr;
  logic [`RV_XLEN-1:0]        wdata_q;
  logic [`RV_NR_REGS-1:1]     waddr_onehot;
  logic [`RV_NR_REGS-1:1]     mem_clk;
  logic [`RV_XLEN-1:0]        mem [`RV_NR_REGS];

  // write clock gate, enable captured while clk is low
  always_latch begin
    if (!clk) we_en_q = we_i;
  end

  assign clk_wr = clk & we_en_q;

  // write data sampled at the end of the write cycle
  always_ff @(posedge clk_wr) begin
    wdata_q <= wdata_i;
  end

  // x0 is hardwired
  assign mem[0] = '0;

  for (genvar w = 1; w < `RV_NR_REGS; w++) begin : g_word
    logic word_en_q;

    assign waddr_onehot[w] = we_i && (waddr_i == w);

    // per word gate on the write clock
    always_latch begin
      if (!clk_wr) word_en_q = waddr_onehot[w];
    end

    assign mem_clk[w] = clk_wr & word_en_q;

    // transparent during the high phase after the sampling edge
    always_latch begin
      if (mem_clk[w]) mem[w] = wdata_q;
    end
  end

  for (genvar p = 0; p < 2; p++) begin : g_read
    assign rdata_o[p] = mem[raddr_i[p]];
  end

endmodule

`default_nettype wire

// File: src/operand_fetch.sv
// ------------------------------
// operand fetch with two level forwarding
// ------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "rv_exec_defs.svh"

module operand_fetch (
  input  logic                        clk,
  input  logic                        arst_n_i,
  input  rv_exec_pkg::dec_op_t        dec_i,
  // distance 1 and 2 bypass
  input  rv_exec_pkg::wb_t            ex_fwd_i,
  input  rv_exec_pkg::wb_t            wb_fwd_i,
  // register file
  output logic [1:0][`RV_REG_AW-1:0]  raddr_o,
  input  logic [1:0][`RV_XLEN-1:0]    rdata_i,
  output rv_exec_pkg::exe_op_t        exe_o
);

  import rv_exec_pkg::*;

  logic [`RV_XLEN-1:0] src_a;
  logic [`RV_XLEN-1:0] src_b;
  logic [`RV_XLEN-1:0] op_b;

  logic                  valid_q;
  logic                  illegal_q;
  alu_op_e               alu_op_q;
  logic [`RV_REG_AW-1:0] rd_q;
  logic [`RV_XLEN-1:0]   a_q;
  logic [`RV_XLEN-1:0]   b_q;

  // newest in-flight value wins, x0 is never forwarded
  function automatic logic [`RV_XLEN-1:0] fwd_sel(
    input logic [`RV_REG_AW-1:0] rs,
    input wb_t                   ex,
    input wb_t                   wb,
    input logic [`RV_XLEN-1:0]   rf
  );
    if (ex.valid && ex.rd != '0 && ex.rd == rs) return ex.data;
    if (wb.valid && wb.rd != '0 && wb.rd == rs) return wb.data;
    return rf;
  endfunction

  assign raddr_o[0] = dec_i.rs1;
  assign raddr_o[1] = dec_i.rs2;

  assign src_a = fwd_sel(dec_i.rs1, ex_fwd_i, wb_fwd_i, rdata_i[0]);
  assign src_b = fwd_sel(dec_i.rs2, ex_fwd_i, wb_fwd_i, rdata_i[1]);
  assign op_b  = dec_i.use_imm ? dec_i.imm : src_b;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q   <= 1'b0;
      illegal_q <= 1'b0;
    end else begin
      valid_q   <= dec_i.valid;
      illegal_q <= dec_i.illegal;
    end
  end

  always_ff @(posedge clk) begin
    alu_op_q <= dec_i.alu_op;
    rd_q     <= dec_i.rd;
    a_q      <= src_a;
    b_q      <= op_b;
  end

  assign exe_o = '{valid: valid_q, illegal: illegal_q, alu_op: alu_op_q, rd: rd_q,
                   a: a_q, b: b_q};

endmodule

`default_nettype wire

// File: src/rv_exec_core.sv
// ------------------------------
// three stage execution pipeline top
// ------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "rv_exec_defs.svh"

module rv_exec_core (
  input  logic                clk,
  input  logic                arst_n_i,
  // instruction stream
  input  logic                instr_valid_i,
  input  rv_exec_pkg::instr_t instr_i,
  // retired result
  output rv_exec_pkg::wb_t    wb_o
);

  import rv_exec_pkg::*;

  dec_op_t                     dec;
  exe_op_t                     exe;
  wb_t                         ex_fwd;
  logic [1:0][`RV_REG_AW-1:0]  rf_raddr;
  logic [1:0][`RV_XLEN-1:0]    rf_rdata;
  logic                        rf_we;

  // writes to x0 are dropped here
  assign rf_we = wb_o.valid & (|wb_o.rd);

  instr_decoder i_decoder (
    .clk           ( clk           ),
    .arst_n_i      ( arst_n_i      ),
    .instr_valid_i ( instr_valid_i ),
    .instr_i       ( instr_i       ),
    .dec_o         ( dec           )
  );

  operand_fetch i_fetch (
    .clk      ( clk      ),
    .arst_n_i ( arst_n_i ),
    .dec_i    ( dec      ),
    .ex_fwd_i ( ex_fwd   ),
    .wb_fwd_i ( wb_o     ),
    .raddr_o  ( rf_raddr ),
    .rdata_i  ( rf_rdata ),
    .exe_o    ( exe      )
  );

  alu_stage i_alu (
    .clk      ( clk      ),
    .arst_n_i ( arst_n_i ),
    .exe_i    ( exe      ),
    .ex_fwd_o ( ex_fwd   ),
    .wb_o     ( wb_o     )
  );

  latch_regfile i_regfile (
    .clk     ( clk       ),
    .raddr_i ( rf_raddr  ),
    .rdata_o ( rf_rdata  ),
    .we_i    ( rf_we     ),
    .waddr_i ( wb_o.rd   ),
    .wdata_i ( wb_o.data )
  );

endmodule

`default_nettype wire

// File: src/rv_exec_pkg.sv
// ------------------------------
// instruction views, stage records and ALU op encoding
// ------------------------------

`default_nettype none

`include "rv_exec_defs.svh"

package rv_exec_pkg;

  // register-register format
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_type_t;

  // register-immediate format
  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_type_t;

  // opcode decides which view applies
  typedef union packed {
    r_type_t r;
    i_type_t i;
  } instr_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU
  } alu_op_e;

  // decode stage output
  typedef struct packed {
    logic                  valid;
    logic                  illegal;
    alu_op_e               alu_op;
    logic [`RV_REG_AW-1:0] rd;
    logic [`RV_REG_AW-1:0] rs1;
    logic [`RV_REG_AW-1:0] rs2;
    logic                  use_imm;
    logic [`RV_XLEN-1:0]   imm;
  } dec_op_t;

  // execute stage input with resolved operands
  typedef struct packed {
    logic                  valid;
    logic                  illegal;
    alu_op_e               alu_op;
    logic [`RV_REG_AW-1:0] rd;
    logic [`RV_XLEN-1:0]   a;
    logic [`RV_XLEN-1:0]   b;
  } exe_op_t;

  // writeback record, also used for forwarding
  typedef struct packed {
    logic                  valid;
    logic                  illegal;
    logic [`RV_REG_AW-1:0] rd;
    logic [`RV_XLEN-1:0]   data;
  } wb_t;

endpackage

`default_nettype wire

// File: tests/rv_exec_core_assert.sv
// ------------------------------
// pipeline flag checks bound to the core
// ------------------------------

`timescale 1ns/100ps
`default_nettype none

module rv_exec_core_assert (
  input logic             clk,
  input logic             arst_n_i,
  input logic             instr_valid_i,
  input rv_exec_pkg::wb_t wb_o
);

  int unsigned fail_cnt = 0;

  // flags low on the first edge after reset release
  a_reset_quiet: assert property (@(posedge clk)
    $rose(arst_n_i) |-> !(wb_o.valid || wb_o.illegal))
    else begin
      fail_cnt++;
      $error("wb_o flags not low after reset");
    end

  // each accepted instruction retires as exactly one of valid or illegal
  a_retire_one: assert property (@(posedge clk) disable iff (!arst_n_i)
    instr_valid_i |-> ##3 (wb_o.valid ^ wb_o.illegal))
    else begin
      fail_cnt++;
      $error("accepted instruction did not retire with exactly one flag");
    end

  // an empty slot stays empty
  a_idle_slot: assert property (@(posedge clk) disable iff (!arst_n_i)
    !instr_valid_i |-> ##3 !(wb_o.valid || wb_o.illegal))
    else begin
      fail_cnt++;
      $error("wb_o flag raised for a slot without an instruction");
    end

endmodule

bind rv_exec_core rv_exec_core_assert u_assert (
  .clk           ( clk           ),
  .arst_n_i      ( arst_n_i      ),
  .instr_valid_i ( instr_valid_i ),
  .wb_o          ( wb_o          )
);

`default_nettype wire

// File: tests/rv_exec_core_tb.sv
// ------------------------------
// testbench with shadow register model
// ------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "rv_exec_defs.svh"

module rv_exec_core_tb;

  import rv_exec_pkg::*;

  localparam int CLK_PERIOD = 8;
  localparam int N_FILL     = 15;
  localparam int N_RAND     = 400;
  localparam int TIMEOUT_NS = (N_FILL + N_RAND + 20) * CLK_PERIOD;

  logic        clk;
  logic        arst_n_i;
  logic        instr_valid_i;
  instr_t      instr_i;
  wb_t         wb_o;

  logic [31:0] lfsr_q;
  logic [31:0] shadow [`RV_NR_REGS];
  logic [3:0]  rd_hist [3];
  wb_t         exp_q [$];
  string       name_q [$];
  int unsigned check_cnt;
  int unsigned flag_err;
  int unsigned data_err;
  logic [31:0] word;

  rv_exec_core DUT (
    .clk           ( clk           ),
    .arst_n_i      ( arst_n_i      ),
    .instr_valid_i ( instr_valid_i ),
    .instr_i       ( instr_i       ),
    .wb_o          ( wb_o          )
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // source at distance 1, 2 or 3, or any register
  function automatic logic [3:0] pick_src(input logic [1:0] sel);
    if (sel == 2'd3) return 4'(take_bits(4));
    return rd_hist[sel];
  endfunction

  task automatic gen_random(output logic [31:0] w);
    logic [3:0]  kind;
    logic [3:0]  rd;
    logic [3:0]  rs1;
    logic [3:0]  rs2;
    logic [3:0]  op_sel;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm;
    kind = 4'(take_bits(4));
    rd   = 4'(take_bits(4));
    rs1  = pick_src(2'(take_bits(2)));
    rs2  = pick_src(2'(take_bits(2)));
    if (take_bits(1) == 32'd1) begin
      op_sel = 4'(take_bits(4) % 10);
      f3     = (op_sel == 0 || op_sel == 1) ? 3'd0 : (op_sel == 7) ? 3'd5 : 3'(op_sel - 1);
      if (op_sel >= 8) f3 = 3'(op_sel - 2);
      f7     = (op_sel == 1 || op_sel == 7) ? 7'h20 : 7'h00;
      w      = {f7, 1'b0, rs2, 1'b0, rs1, f3, 1'b0, rd, `RV_OPC_OP};
    end else begin
      f3  = 3'(take_bits(3));
      imm = 12'(take_bits(12));
      // shift immediates carry funct7 in the upper bits
      if (f3 == 3'd1) imm[11:5] = 7'h00;
      if (f3 == 3'd5) imm[11:5] = imm[11] ? 7'h20 : 7'h00;
      w = {imm, 1'b0, rs1, f3, 1'b0, rd, `RV_OPC_OP_IMM};
    end
    if (kind == 4'd0) begin
      case (2'(take_bits(2)))
        2'd0: w[6:0] = 7'b0000011;
        2'd1: w[11] = 1'b1;
        2'd2: w[19] = 1'b1;
        default: begin
          w[6:0]   = `RV_OPC_OP;
          w[31:25] = 7'h01;
        end
      endcase
    end
  endtask

  // reference result from the RV32E OP and OP-IMM rules
  task automatic predict(input logic [31:0] w, output wb_t exp, output string name);
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic        is_imm;
    logic        alt;
    logic        ok;
    rd     = w[11:7];
    f3     = w[14:12];
    rs1    = w[19:15];
    rs2    = w[24:20];
    f7     = w[31:25];
    is_imm = (w[6:0] == `RV_OPC_OP_IMM);
    alt    = (f7 == 7'h20);
    ok     = (w[6:0] == `RV_OPC_OP) || is_imm;
    if (w[6:0] == `RV_OPC_OP) ok = (f7 == 7'h00) || (alt && (f3 == 3'd0 || f3 == 3'd5));
    if (is_imm && f3 == 3'd1) ok = (f7 == 7'h00);
    if (is_imm && f3 == 3'd5) ok = (f7 == 7'h00) || alt;
    if (rd[4] || rs1[4] || (!is_imm && rs2[4])) ok = 1'b0;
    a = shadow[rs1[3:0]];
    b = is_imm ? {{20{w[31]}}, w[31:20]} : shadow[rs2[3:0]];
    case (f3)
      3'd0: begin
        res  = (alt && !is_imm) ? a - b : a + b;
        name = (alt && !is_imm) ? "sub" : "add";
      end
      3'd1: begin
        res  = a << b[4:0];
        name = "sll";
      end
      3'd2: begin
        res  = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        name = "slt";
      end
      3'd3: begin
        res  = (a < b) ? 32'd1 : 32'd0;
        name = "sltu";
      end
      3'd4: begin
        res  = a ^ b;
        name = "xor";
      end
      3'd5: begin
        res  = alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
        name = alt ? "sra" : "srl";
      end
      3'd6: begin
        res  = a | b;
        name = "or";
      end
      default: begin
        res  = a & b;
        name = "and";
      end
    endcase
    if (is_imm) name = {name, "i"};
    if (!ok) name = "illegal";
    exp = '{valid: ok, illegal: !ok, rd: rd[3:0], data: res};
    // x0 stays zero even though the result is reported
    if (ok && rd[3:0] != 4'd0) shadow[rd[3:0]] = res;
  endtask

  task automatic check_wb();
    wb_t   exp;
    string name;
    if (exp_q.size() == 3) begin
      exp  = exp_q.pop_front();
      name = name_q.pop_front();
      check_cnt++;
      assert (wb_o.valid === exp.valid && wb_o.illegal === exp.illegal)
      else begin
        flag_err++;
        $display("error %s flags: expected v=%b i=%b actual v=%b i=%b", name,
                 exp.valid, exp.illegal, wb_o.valid, wb_o.illegal);
      end
      if (exp.valid) begin
        assert ({wb_o.rd, wb_o.data} === {exp.rd, exp.data})
        else begin
          data_err++;
          $display("error %s: expected x%0d=%h actual x%0d=%h", name,
                   exp.rd, exp.data, wb_o.rd, wb_o.data);
        end
      end
    end
  endtask

  // one slot per falling edge, check first and then drive
  task automatic issue(input logic [31:0] w, input logic vld);
    wb_t   exp;
    string name;
    @(negedge clk);
    check_wb();
    instr_valid_i = vld;
    instr_i       = w;
    if (vld) begin
      predict(w, exp, name);
      rd_hist[2] = rd_hist[1];
      rd_hist[1] = rd_hist[0];
      rd_hist[0] = w[10:7];
    end else begin
      exp  = '0;
      name = "idle";
    end
    exp_q.push_back(exp);
    name_q.push_back(name);
  endtask

  initial begin
    clk           = 1'b0;
    arst_n_i      = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    lfsr_q        = 32'h8511;
    check_cnt     = 0;
    flag_err      = 0;
    data_err      = 0;
    for (int r = 0; r < `RV_NR_REGS; r++) shadow[r] = '0;
    for (int h = 0; h < 3; h++) rd_hist[h] = '0;
    repeat (2) @(negedge clk);
    arst_n_i = 1'b1;
    // addi from x0 into x1 to x15
    for (int r = 1; r <= N_FILL; r++) begin
      word = {12'(take_bits(12)), 5'd0, 3'b000, 5'(r), `RV_OPC_OP_IMM};
      issue(word, 1'b1);
    end
    for (int n = 0; n < N_RAND; n++) begin
      gen_random(word);
      issue(word, 1'b1);
    end
    repeat (4) issue('0, 1'b0);
    $display("checks %0d, flag errors %0d, data errors %0d, assertion failures %0d",
             check_cnt, flag_err, data_err, DUT.u_assert.fail_cnt);
    if (flag_err == 0 && data_err == 0 && DUT.u_assert.fail_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: the instruction stream did not finish in time");
    $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire
